/* core_pkg.sv */
/*
 * Integer execution cluster package
 * Sizes, register and data types, ALU opcodes and the packets passed
 * between issue, the execution lanes and writeback
 */
package core_pkg;

    // Cluster sizes
    localparam int NUM_PHYS_REGS = 64;     // Physical registers, reg 0 is hardwired zero
    localparam int NUM_LANES     = 2;      // Execution lanes, one writeback port each
    localparam int XLEN          = 64;     // Datapath width
    localparam int PHREG_W       = $clog2(NUM_PHYS_REGS);
    localparam int LANE_IDX_W    = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int SHAMT_W       = 6;      // Shift amount taken from operand 2

    typedef logic [PHREG_W-1:0]    phreg_t;     // Physical register index
    typedef logic [XLEN-1:0]       bus64_t;     // Data word
    typedef logic [LANE_IDX_W-1:0] lane_idx_t;  // Round-robin lane pointer

    // ALU opcodes
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_SLL  = 3'd5,
        OP_SRL  = 3'd6,
        OP_ADDI = 3'd7     // src1 + imm, src2 unused
    } alu_op_e;

    // Instruction at the cluster input
    typedef struct packed {
        logic    valid;
        alu_op_e op;
        phreg_t  dst;
        phreg_t  src1;
        phreg_t  src2;
        bus64_t  imm;
    } issue_pkt_t;

    // Issue to lane, operands already read and bypassed
    typedef struct packed {
        logic    valid;
        alu_op_e op;
        phreg_t  dst;
        bus64_t  opa;
        bus64_t  opb;
    } lane_req_t;

    // Lane result, also used for writeback and retire
    typedef struct packed {
        logic   valid;
        phreg_t dst;
        bus64_t data;
    } wb_t;

endpackage

/* phys_regfile.sv */
/*
 * Physical register file
 * NUM_LANES write ports and two combinational read ports
 * Reads see a same-cycle write through the bypass
 * Register 0 reads as zero and is never stored
 */
module phys_regfile
    import core_pkg::*;
(
    input  logic                     clk_i,

    // Writeback ports
    input  logic   [NUM_LANES-1:0]   we_i,
    input  phreg_t [NUM_LANES-1:0]   waddr_i,
    input  bus64_t [NUM_LANES-1:0]   wdata_i,

    // Read ports
    input  phreg_t                   raddr1_i,
    input  phreg_t                   raddr2_i,
    output bus64_t                   rdata1_o,
    output bus64_t                   rdata2_o
);

    // No storage behind register 0
    bus64_t regs_q [1:NUM_PHYS_REGS-1];

    logic   hit1;       // Port 1 matches a write in flight
    logic   hit2;
    bus64_t fwd1;       // Forwarded write data for port 1
    bus64_t fwd2;

    // Bypass search over all write ports
    always_comb begin
        hit1 = 1'b0;
        hit2 = 1'b0;
        fwd1 = '0;
        fwd2 = '0;
        for (int p = 0; p < NUM_LANES; p++) begin
            if (we_i[p] && (waddr_i[p] == raddr1_i)) begin
                hit1 = 1'b1;
                fwd1 = wdata_i[p];      // Ports never share a dst in one cycle
            end
            if (we_i[p] && (waddr_i[p] == raddr2_i)) begin
                hit2 = 1'b1;
                fwd2 = wdata_i[p];
            end
        end
    end

    // Read mux, zero register first
    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else if (hit1) begin
            rdata1_o = fwd1;
        end else begin
            rdata1_o = regs_q[raddr1_i];
        end

        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else if (hit2) begin
            rdata2_o = fwd2;
        end else begin
            rdata2_o = regs_q[raddr2_i];
        end
    end

    // Write ports, register 0 dropped
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NUM_LANES; p++) begin
            if (we_i[p] && (waddr_i[p] != '0)) begin
                regs_q[waddr_i[p]] <= wdata_i[p];
            end
        end
    end

endmodule

/* scoreboard.sv */
/*
 * Scoreboard
 * One busy bit per physical register, set when an instruction
 * is accepted and cleared when its result is written back
 * A clear in the current cycle already shows the register free
 */
module scoreboard
    import core_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    // Set from issue
    input  logic                       set_valid_i,
    input  phreg_t                     set_reg_i,

    // Clears from writeback
    input  logic   [NUM_LANES-1:0]     clr_valid_i,
    input  phreg_t [NUM_LANES-1:0]     clr_reg_i,

    output logic   [NUM_PHYS_REGS-1:0] busy_o
);

    logic [NUM_PHYS_REGS-1:0] busy_q;
    logic [NUM_PHYS_REGS-1:0] set_mask;
    logic [NUM_PHYS_REGS-1:0] clr_mask;

    // Decode set and clear requests into masks
    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (set_valid_i) begin
            set_mask[set_reg_i] = 1'b1;
        end
        for (int p = 0; p < NUM_LANES; p++) begin
            if (clr_valid_i[p]) begin
                clr_mask[clr_reg_i[p]] = 1'b1;
            end
        end
        set_mask[0] = 1'b0;     // Reg 0 never tracked
    end

    // Set wins over clear, a WAW issue lands on the writeback cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            busy_q <= (busy_q & ~clr_mask) | set_mask;
        end
    end

    // Early release through the clears
    assign busy_o = busy_q & ~clr_mask;

endmodule

/* issue_unit.sv */
/*
 * Issue unit
 * Checks the presented instruction against the scoreboard,
 * reads its operands and sends it to the next lane in
 * round-robin order, one instruction per cycle at most
 */
module issue_unit
    import core_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    // Instruction input
    input  issue_pkt_t                    issue_i,
    output logic                          issue_ready_o,

    // Scoreboard
    input  logic      [NUM_PHYS_REGS-1:0] busy_i,
    output logic                          sb_set_valid_o,
    output phreg_t                        sb_set_reg_o,

    // Register file read
    output phreg_t                        rf_raddr1_o,
    output phreg_t                        rf_raddr2_o,
    input  bus64_t                        rf_rdata1_i,
    input  bus64_t                        rf_rdata2_i,

    // Lane requests
    output lane_req_t [NUM_LANES-1:0]     lane_req_o
);

    lane_idx_t lane_ptr_q;      // Lane that takes the next instruction
    logic      uses_src2;
    logic      hazard;
    logic      accept;
    bus64_t    opb;

    assign uses_src2 = (issue_i.op != OP_ADDI);    // ADDI reads src1 only

    // RAW on either source, WAW on the destination
    assign hazard = busy_i[issue_i.src1]
                  | (uses_src2 & busy_i[issue_i.src2])
                  | busy_i[issue_i.dst];

    assign issue_ready_o = ~hazard;
    assign accept        = issue_i.valid & issue_ready_o;

    // Operand read
    assign rf_raddr1_o = issue_i.src1;
    assign rf_raddr2_o = issue_i.src2;
    assign opb         = uses_src2 ? rf_rdata2_i : issue_i.imm;

    // Mark the destination pending
    assign sb_set_valid_o = accept;
    assign sb_set_reg_o   = issue_i.dst;

    // Same payload on every lane, only the selected one sees valid
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_req_o[l].valid = accept && (lane_ptr_q == lane_idx_t'(l));
            lane_req_o[l].op    = issue_i.op;
            lane_req_o[l].dst   = issue_i.dst;
            lane_req_o[l].opa   = rf_rdata1_i;
            lane_req_o[l].opb   = opb;
        end
    end

    // Round-robin pointer, advances on every acceptance
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lane_ptr_q <= '0;
        end else if (accept) begin
            if (lane_ptr_q == lane_idx_t'(NUM_LANES - 1)) begin
                lane_ptr_q <= '0;       // Wrap
            end else begin
                lane_ptr_q <= lane_ptr_q + 1'b1;
            end
        end
    end

endmodule

/* exec_lane.sv */
/*
 * Integer execution lane
 * Stage 1 captures the request, stage 2 computes the ALU result
 * and holds it for writeback, fixed latency of two cycles
 */
module exec_lane
    import core_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  lane_req_t req_i,
    output wb_t       wb_o
);

    // Stage 1
    logic    s1_valid_q;
    alu_op_e s1_op_q;
    phreg_t  s1_dst_q;
    bus64_t  s1_opa_q;
    bus64_t  s1_opb_q;

    // Stage 2
    logic    s2_valid_q;
    phreg_t  s2_dst_q;
    bus64_t  s2_data_q;

    bus64_t  alu_res;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= req_i.valid;
            s2_valid_q <= s1_valid_q;
        end
    end

    // Payload moves only with a valid entry
    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            s1_op_q  <= req_i.op;
            s1_dst_q <= req_i.dst;
            s1_opa_q <= req_i.opa;
            s1_opb_q <= req_i.opb;
        end
        if (s1_valid_q) begin
            s2_dst_q  <= s1_dst_q;
            s2_data_q <= alu_res;
        end
    end

    // ALU
    always_comb begin
        case (s1_op_q)
            OP_ADD,
            OP_ADDI: alu_res = s1_opa_q + s1_opb_q;   // opb holds imm for ADDI
            OP_SUB:  alu_res = s1_opa_q - s1_opb_q;
            OP_AND:  alu_res = s1_opa_q & s1_opb_q;
            OP_OR:   alu_res = s1_opa_q | s1_opb_q;
            OP_XOR:  alu_res = s1_opa_q ^ s1_opb_q;
            OP_SLL:  alu_res = s1_opa_q << s1_opb_q[SHAMT_W-1:0];
            OP_SRL:  alu_res = s1_opa_q >> s1_opb_q[SHAMT_W-1:0];  // Logical
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        wb_o.valid = s2_valid_q;
        wb_o.dst   = s2_dst_q;
        wb_o.data  = s2_data_q;
    end

endmodule

/* wb_collector.sv */
/*
 * Writeback collector
 * Maps each lane result onto its register file write port,
 * releases the scoreboard entry and builds the retire report
 */
module wb_collector
    import core_pkg::*;
(
    input  wb_t    [NUM_LANES-1:0] lane_wb_i,

    // Register file write ports
    output logic   [NUM_LANES-1:0] rf_we_o,
    output phreg_t [NUM_LANES-1:0] rf_waddr_o,
    output bus64_t [NUM_LANES-1:0] rf_wdata_o,

    // Scoreboard clears
    output logic   [NUM_LANES-1:0] sb_clr_valid_o,
    output phreg_t [NUM_LANES-1:0] sb_clr_reg_o,

    // Retire report
    output wb_t    [NUM_LANES-1:0] retire_o
);

    always_comb begin
        for (int p = 0; p < NUM_LANES; p++) begin
            // Lane p owns write port p
            rf_we_o[p]    = lane_wb_i[p].valid;
            rf_waddr_o[p] = lane_wb_i[p].dst;
            rf_wdata_o[p] = lane_wb_i[p].data;

            sb_clr_valid_o[p] = lane_wb_i[p].valid;
            sb_clr_reg_o[p]   = lane_wb_i[p].dst;

            // Retire record, payload zeroed on idle ports
            retire_o[p].valid = lane_wb_i[p].valid;
            if (lane_wb_i[p].valid) begin
                retire_o[p].dst  = lane_wb_i[p].dst;
                retire_o[p].data = lane_wb_i[p].data;
            end else begin
                retire_o[p].dst  = '0;
                retire_o[p].data = '0;
            end
        end
    end

endmodule

/* exec_cluster.sv */
/*
 * Integer execution cluster
 * Issue unit, scoreboard, physical register file, NUM_LANES
 * ALU lanes and the writeback collector
 */
module exec_cluster
    import core_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  issue_pkt_t             issue_i,
    output logic                   issue_ready_o,
    output wb_t [NUM_LANES-1:0]    retire_o
);

    logic      [NUM_PHYS_REGS-1:0] busy;
    logic                          sb_set_valid;
    phreg_t                        sb_set_reg;
    logic      [NUM_LANES-1:0]     sb_clr_valid;
    phreg_t    [NUM_LANES-1:0]     sb_clr_reg;

    phreg_t                        rf_raddr1;
    phreg_t                        rf_raddr2;
    bus64_t                        rf_rdata1;
    bus64_t                        rf_rdata2;
    logic      [NUM_LANES-1:0]     rf_we;
    phreg_t    [NUM_LANES-1:0]     rf_waddr;
    bus64_t    [NUM_LANES-1:0]     rf_wdata;

    lane_req_t [NUM_LANES-1:0]     lane_req;
    wb_t       [NUM_LANES-1:0]     lane_wb;

    issue_unit issue_unit_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .issue_i        (issue_i),
        .issue_ready_o  (issue_ready_o),
        .busy_i         (busy),
        .sb_set_valid_o (sb_set_valid),
        .sb_set_reg_o   (sb_set_reg),
        .rf_raddr1_o    (rf_raddr1),
        .rf_raddr2_o    (rf_raddr2),
        .rf_rdata1_i    (rf_rdata1),
        .rf_rdata2_i    (rf_rdata2),
        .lane_req_o     (lane_req)
    );

    scoreboard scoreboard_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .set_valid_i (sb_set_valid),
        .set_reg_i   (sb_set_reg),
        .clr_valid_i (sb_clr_valid),
        .clr_reg_i   (sb_clr_reg),
        .busy_o      (busy)
    );

    phys_regfile phys_regfile_i (
        .clk_i    (clk_i),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    // One ALU lane per writeback port
    for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane
        exec_lane exec_lane_i (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .req_i   (lane_req[g]),
            .wb_o    (lane_wb[g])
        );
    end

    wb_collector wb_collector_i (
        .lane_wb_i      (lane_wb),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .sb_clr_valid_o (sb_clr_valid),
        .sb_clr_reg_o   (sb_clr_reg),
        .retire_o       (retire_o)
    );

endmodule

/* tb_exec_cluster.sv */
/*
 * Testbench for the integer execution cluster
 * Applies a table of instructions through the issue handshake,
 * keeps a reference model of the 64 registers and checks every
 * retired result, its destination and its lane against the model
 */
module tb_exec_cluster
    import core_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DLY      = 2;     // Input skew after the rising edge
    localparam int RESET_CYCLES   = 5;
    localparam int TIMEOUT_CYCLES = 20;

    logic                  clk_i;
    logic                  rst_n_i;
    issue_pkt_t            issue_i;
    logic                  issue_ready_o;
    wb_t [NUM_LANES-1:0]   retire_o;

    // Stimulus table
    string      tbl_name[$];
    issue_pkt_t tbl_pkt[$];
    bit         tbl_rnd[$];        // Replace imm with a random word
    bit         tbl_burst[$];      // Must issue without a stall

    // Reference model and expected results in issue order
    bus64_t ref_regs [NUM_PHYS_REGS];
    int     exp_idx_q[$];
    phreg_t exp_dst_q[$];
    bus64_t exp_data_q[$];
    int     exp_lane_q[$];

    logic [31:0] lfsr_state = 32'h194c9f99;
    int          accept_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          errors = 0;

    exec_cluster exec_cluster_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .retire_o      (retire_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // One Galois step, right shifting form
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic draw_rand64(output bus64_t v);
        v = '0;
        for (int i = 0; i < XLEN; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v[i] = lfsr_state[0];          // One step per bit
        end
    endtask

    // Opcode rules, shifts take the low 6 bits of operand 2
    function automatic bus64_t compute_expected(input alu_op_e op, input bus64_t a,
                                                input bus64_t b);
        case (op)
            OP_ADD, OP_ADDI: return a + b;
            OP_SUB:          return a - b;
            OP_AND:          return a & b;
            OP_OR:           return a | b;
            OP_XOR:          return a ^ b;
            OP_SLL:          return a << b[5:0];
            OP_SRL:          return a >> b[5:0];
            default:         return '0;
        endcase
    endfunction

    task automatic add_test(input string name, input alu_op_e op, input int dst, input int s1,
                            input int s2, input bus64_t imm, input bit rnd, input bit burst);
        issue_pkt_t pkt;
        pkt.valid = 1'b0;
        pkt.op    = op;
        pkt.dst   = phreg_t'(dst);
        pkt.src1  = phreg_t'(s1);
        pkt.src2  = phreg_t'(s2);
        pkt.imm   = imm;
        tbl_name.push_back(name);
        tbl_pkt.push_back(pkt);
        tbl_rnd.push_back(rnd);
        tbl_burst.push_back(burst);
    endtask

    task automatic build_table();
        for (int r = 1; r <= 8; r++) begin
            add_test($sformatf("load_r%0d", r), OP_ADDI, r, 0, 0, '0, 1'b1, 1'b1);
        end
        add_test("op_add", OP_ADD, 9, 1, 2, '0, 1'b0, 1'b0);
        add_test("op_sub", OP_SUB, 10, 3, 4, '0, 1'b0, 1'b0);
        add_test("op_and", OP_AND, 11, 5, 6, '0, 1'b0, 1'b0);
        add_test("op_or", OP_OR, 12, 7, 8, '0, 1'b0, 1'b0);
        add_test("op_xor", OP_XOR, 13, 1, 8, '0, 1'b0, 1'b0);
        add_test("op_sll", OP_SLL, 14, 5, 6, '0, 1'b0, 1'b0);
        add_test("op_srl", OP_SRL, 15, 7, 2, '0, 1'b0, 1'b0);
        add_test("op_sub_wrap", OP_SUB, 18, 2, 7, '0, 1'b0, 1'b0);
        // Writes to r0 retire but never land
        add_test("zero_add", OP_ADD, 0, 1, 2, '0, 1'b0, 1'b0);
        add_test("zero_addi", OP_ADDI, 0, 5, 0, '0, 1'b1, 1'b0);
        add_test("zero_read_src1", OP_ADD, 16, 0, 3, '0, 1'b0, 1'b0);
        add_test("zero_read_src2", OP_XOR, 17, 4, 0, '0, 1'b0, 1'b0);
        // Dependent chain, RAW and WAW stalls then bypass
        add_test("chain_addi", OP_ADDI, 20, 1, 0, 64'd5, 1'b0, 1'b0);
        add_test("chain_raw", OP_ADD, 21, 20, 20, '0, 1'b0, 1'b0);
        add_test("chain_raw_waw", OP_SUB, 21, 21, 2, '0, 1'b0, 1'b0);
        add_test("chain_sll", OP_SLL, 22, 21, 3, '0, 1'b0, 1'b0);
        add_test("chain_srl_waw", OP_SRL, 22, 22, 20, '0, 1'b0, 1'b0);
        add_test("waw_first", OP_ADDI, 23, 0, 0, '0, 1'b1, 1'b0);
        add_test("waw_second", OP_ADDI, 23, 1, 0, '0, 1'b1, 1'b0);
        add_test("waw_read", OP_ADD, 24, 23, 0, '0, 1'b0, 1'b0);
        // Independent burst, one per cycle
        add_test("burst_0", OP_ADD, 30, 1, 2, '0, 1'b0, 1'b1);
        add_test("burst_1", OP_XOR, 31, 3, 4, '0, 1'b0, 1'b1);
        // src2 names r31, still busy but unused by ADDI
        add_test("burst_2", OP_ADDI, 32, 5, 31, '0, 1'b1, 1'b1);
        add_test("burst_3", OP_OR, 33, 6, 7, '0, 1'b0, 1'b1);
        add_test("burst_4", OP_SLL, 34, 8, 1, '0, 1'b0, 1'b1);
        add_test("burst_5", OP_SUB, 35, 2, 5, '0, 1'b0, 1'b1);
    endtask

    task automatic finish_run();
        $display("Tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // Model update at acceptance, expected entry queued in issue order
    task automatic expect_result(input int idx, input issue_pkt_t pkt);
        bus64_t a;
        bus64_t b;
        bus64_t res;
        a   = ref_regs[pkt.src1];
        b   = (pkt.op == OP_ADDI) ? pkt.imm : ref_regs[pkt.src2];
        res = compute_expected(pkt.op, a, b);
        if (pkt.dst != '0) begin
            ref_regs[pkt.dst] = res;
        end
        exp_idx_q.push_back(idx);
        exp_dst_q.push_back(pkt.dst);
        exp_data_q.push_back(res);
        exp_lane_q.push_back(accept_count % NUM_LANES);   // Strict alternation from lane 0
        accept_count++;
    endtask

    task automatic issue_entry(input int idx, output bit ok);
        issue_pkt_t pkt;
        bus64_t     rnd_imm;
        int         waited;
        ok  = 1'b1;
        pkt = tbl_pkt[idx];
        if (tbl_rnd[idx]) begin
            draw_rand64(rnd_imm);
            pkt.imm = rnd_imm;
        end
        pkt.valid = 1'b1;
        issue_i   = pkt;
        waited    = 0;
        @(negedge clk_i);                  // Ready is settled mid-cycle
        while (issue_ready_o !== 1'b1 && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(negedge clk_i);
        end
        if (issue_ready_o !== 1'b1) begin
            $display("Timeout: issue_ready_o stayed low for %0d cycles on %s",
                     TIMEOUT_CYCLES, tbl_name[idx]);
            errors++;
            ok = 1'b0;
        end else begin
            if (tbl_burst[idx] && waited != 0) begin
                $display("Unexpected stall: issue_ready_o went low during burst on %s",
                         tbl_name[idx]);
                errors++;
            end
            expect_result(idx, pkt);
            @(posedge clk_i);              // Accepted on this edge
            #DRIVE_DLY;
        end
    endtask

    task automatic check_retire(input int lane, input wb_t r);
        int     idx;
        phreg_t e_dst;
        bus64_t e_data;
        int     e_lane;
        if (exp_idx_q.size() == 0) begin
            $display("Unexpected retire on lane %0d with nothing outstanding", lane);
            errors++;
        end else begin
            idx    = exp_idx_q.pop_front();
            e_dst  = exp_dst_q.pop_front();
            e_data = exp_data_q.pop_front();
            e_lane = exp_lane_q.pop_front();
            if (r.dst !== e_dst || r.data !== e_data) begin
                $display("Fail %s: expected dst %0d data %h, actual dst %0d data %h",
                         tbl_name[idx], e_dst, e_data, r.dst, r.data);
                fail_count++;
                errors++;
            end else if (lane != e_lane) begin
                $display("Fail %s: expected lane %0d, actual lane %0d",
                         tbl_name[idx], e_lane, lane);
                fail_count++;
                errors++;
            end else begin
                $display("Pass %s: lane %0d dst %0d data %h", tbl_name[idx], lane, r.dst, r.data);
                pass_count++;
            end
        end
    endtask

    // Retire monitor, lane order within a cycle
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (retire_o[l].valid === 1'b1) begin
                    check_retire(l, retire_o[l]);
                end
            end
        end
    end

    initial begin
        int waited;
        bit ok;
        rst_n_i = 1'b0;
        issue_i = '0;
        for (int r = 0; r < NUM_PHYS_REGS; r++) begin
            ref_regs[r] = '0;
        end
        build_table();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DLY;
        rst_n_i = 1'b1;

        // State right after reset
        @(negedge clk_i);
        if (issue_ready_o !== 1'b1 || retire_o[0].valid !== 1'b0
                || retire_o[1].valid !== 1'b0) begin
            $display("Fail reset_state: expected ready 1 retire valid 00, %s %b valid %b%b",
                     "actual ready", issue_ready_o, retire_o[1].valid, retire_o[0].valid);
            fail_count++;
            errors++;
        end else begin
            $display("Pass reset_state");
            pass_count++;
        end
        @(posedge clk_i);
        #DRIVE_DLY;

        for (int i = 0; i < tbl_name.size(); i++) begin
            issue_entry(i, ok);
            if (!ok) begin
                break;
            end
        end
        issue_i.valid = 1'b0;

        // Drain the pipeline
        waited = 0;
        while (exp_idx_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(posedge clk_i);
        end
        if (exp_idx_q.size() != 0) begin
            $display("Timeout: %0d results never retired", exp_idx_q.size());
            errors++;
        end
        finish_run();
    end

endmodule

/* project.f */
core_pkg.sv
phys_regfile.sv
scoreboard.sv
issue_unit.sv
exec_lane.sv
wb_collector.sv
exec_cluster.sv
tb_exec_cluster.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = tb_exec_cluster
FILELIST  = project.f
OBJDIR    = obj_dir

.PHONY: sim clean

# Build and run, status comes from the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJDIR)
